// File: list.f
+incdir+.
fa_pkg.sv
line_if.sv
scan_timing.sv
point_window.sv
blink_classifier.sv
config_regs.sv
freq_analyzer_top.sv
fa_assert.sv
tb_freq_analyzer.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f list.f --top-module tb_freq_analyzer \
    -o tb_freq_analyzer

# the log decides the result, a stop by an assertion shows up as a missing pass line
./obj_dir/tb_freq_analyzer > sim.log 2>&1 || true
cat sim.log

if grep -F -q '** FAIL **' sim.log; then
    echo "simulation failed"
    exit 1
fi
if ! grep -F -q '** PASS **' sim.log; then
    echo "simulation ended without a result"
    exit 1
fi

// File: tb_freq_analyzer.sv
`timescale 1ns/10ps
`include "fa_cfg.svh"

module tb_freq_analyzer;

    localparam int LINE_LEN = `FA_DARK_PIXELS + `FA_COLOR_PIXELS + 1;
    // the two runs take 40 lines, leave about twice that
    localparam int TIMEOUT_CYCLES = 80 * LINE_LEN;

    logic                 pixel_clock = 1'b0;
    logic                 rst_n;
    logic                 start;
    logic                 stop;
    logic                 clear;
    fa_pkg::pixel_t       data;
    logic                 cfg_write;
    fa_pkg::cfg_addr_e    cfg_addr;
    fa_pkg::index_t       cfg_data;
    fa_pkg::result_addr_e read_addr;
    fa_pkg::result_t      read_data;
    logic                 done;

    // reference model state
    fa_pkg::pixel_t  line_buf [LINE_LEN];
    fa_pkg::window_t windows [`FA_POINTS];
    fa_pkg::pixel_t  threshold_model;
    fa_pkg::result_t exp_f0 [`FA_POINTS];
    fa_pkg::result_t exp_f1 [`FA_POINTS];
    fa_pkg::result_t exp_unknown [`FA_POINTS];
    logic            prev_light [`FA_POINTS];
    logic            armed [`FA_POINTS];
    int              last_rise [`FA_POINTS];
    // period 0 keeps a point dark
    int              blink_period [`FA_POINTS];
    int              bright_lo [`FA_POINTS];
    int              bright_hi [`FA_POINTS];
    int              cycle_count = 0;

    freq_analyzer_top i_dut (
        .pixel_clock (pixel_clock),
        .rst_n       (rst_n),
        .start       (start),
        .stop        (stop),
        .clear       (clear),
        .data        (data),
        .cfg_write   (cfg_write),
        .cfg_addr    (cfg_addr),
        .cfg_data    (cfg_data),
        .read_addr   (read_addr),
        .read_data   (read_data),
        .done        (done)
    );

    always #10 pixel_clock = ~pixel_clock;

    always @(posedge pixel_clock)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES)
        begin
            $display("timeout, the test sequence did not finish in %0d cycles", cycle_count);
            $display("** FAIL **");
            $fatal(1);
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic expected_light(input fa_pkg::pixel_t pixels [LINE_LEN],
                                            input fa_pkg::window_t win,
                                            input fa_pkg::pixel_t thr);
        int hi;
        int lo;
        int mid;
        hi = 0;
        lo = 255;
        for (int i = int'(win.start); i < int'(win.stop); i++)
        begin
            if (int'(pixels[i]) > hi)
                hi = int'(pixels[i]);
            if (int'(pixels[i]) < lo)
                lo = int'(pixels[i]);
        end
        mid = lo + (hi - lo) / 2;
        return mid > int'(thr);
    endfunction

    task automatic classify(input int p, input int period);
        if (period >= `FA_F0_PERIOD - `FA_DEVIATION && period <= `FA_F0_PERIOD + `FA_DEVIATION)
            exp_f0[p] = exp_f0[p] + fa_pkg::result_t'(period);
        else if (period >= `FA_F1_PERIOD - `FA_DEVIATION &&
                 period <= `FA_F1_PERIOD + `FA_DEVIATION)
            exp_f1[p] = exp_f1[p] + fa_pkg::result_t'(period);
        else
            exp_unknown[p] = exp_unknown[p] + fa_pkg::result_t'(period);
    endtask

    task automatic update_model(input int n);
        logic lt;
        for (int p = 0; p < `FA_POINTS; p++)
        begin
            lt = expected_light(line_buf, windows[p], threshold_model);
            if (lt && !prev_light[p])
            begin
                // first rise of a run only arms
                if (armed[p])
                    classify(p, n - last_rise[p]);
                armed[p] = 1'b1;
                last_rise[p] = n;
            end
            prev_light[p] = lt;
        end
    endtask

    task automatic clear_model();
        for (int p = 0; p < `FA_POINTS; p++)
        begin
            exp_f0[p] = '0;
            exp_f1[p] = '0;
            exp_unknown[p] = '0;
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////////////////////

    task automatic set_pattern(input int p, input int period, input int lo, input int hi);
        blink_period[p] = period;
        bright_lo[p] = lo;
        bright_hi[p] = hi;
    endtask

    // noise stays well below any threshold, bright square near full scale
    task automatic generate_line(input int n);
        for (int i = 0; i < LINE_LEN; i++)
            line_buf[i] = fa_pkg::pixel_t'($urandom % 40);
        for (int p = 0; p < `FA_POINTS; p++)
        begin
            if (blink_period[p] != 0 && (n % blink_period[p]) < blink_period[p] / 2)
            begin
                for (int i = bright_lo[p]; i < bright_hi[p]; i++)
                    line_buf[i] = fa_pkg::pixel_t'(220 + $urandom % 36);
            end
        end
    endtask

    task automatic write_cfg(input fa_pkg::cfg_addr_e addr, input int value);
        @(posedge pixel_clock);
        cfg_write <= 1'b1;
        cfg_addr  <= addr;
        cfg_data  <= fa_pkg::index_t'(value);
        @(posedge pixel_clock);
        cfg_write <= 1'b0;
    endtask

    task automatic check_value(input string name, input fa_pkg::result_t got,
                               input fa_pkg::result_t exp);
        assert (got === exp)
        else
        begin
            $display("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp);
            $display("** FAIL **");
            $fatal(1);
        end
    endtask

    task automatic run_lines(input int lines);
        for (int p = 0; p < `FA_POINTS; p++)
        begin
            prev_light[p] = 1'b0;
            armed[p] = 1'b0;
        end
        for (int n = 0; n < lines; n++)
        begin
            generate_line(n);
            update_model(n);
            for (int i = 0; i < LINE_LEN; i++)
            begin
                @(posedge pixel_clock);
                // start was taken one edge ago
                if (n == 0 && i == 2)
                    check_value("done", fa_pkg::result_t'(done), '0);
                data  <= line_buf[i];
                start <= (n == 0 && i == 0);
            end
        end
        @(posedge pixel_clock);
        stop <= 1'b1;
        @(posedge pixel_clock);
        stop <= 1'b0;
        while (done !== 1'b1)
            @(negedge pixel_clock);
    endtask

    task automatic read_result(input fa_pkg::result_addr_e addr, output fa_pkg::result_t value);
        @(posedge pixel_clock);
        read_addr <= addr;
        @(posedge pixel_clock);
        @(negedge pixel_clock);
        value = read_data;
    endtask

    task automatic check_results();
        fa_pkg::result_t value;
        for (int p = 0; p < `FA_POINTS; p++)
        begin
            read_result(fa_pkg::result_addr_e'(4'(2 * p)), value);
            check_value($sformatf("p%0d_f0_time", p), value, exp_f0[p]);
            read_result(fa_pkg::result_addr_e'(4'(2 * p + 1)), value);
            check_value($sformatf("p%0d_f1_time", p), value, exp_f1[p]);
            read_result(fa_pkg::result_addr_e'(4'(6 + p)), value);
            check_value($sformatf("p%0d_unknown_time", p), value, exp_unknown[p]);
        end
        read_result(fa_pkg::result_addr_e'(4'd12), value);
        check_value("read_data unmapped", value, '0);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////////////////////

    initial
    begin
        fa_pkg::result_t value;
        void'($urandom(32'habcf_349f));
        rst_n     = 1'b0;
        start     = 1'b0;
        stop      = 1'b0;
        clear     = 1'b0;
        data      = '0;
        cfg_write = 1'b0;
        cfg_addr  = fa_pkg::THRESHOLD;
        cfg_data  = '0;
        read_addr = fa_pkg::P0_F0;
        threshold_model = fa_pkg::pixel_t'(`FA_DEF_THRESHOLD);
        windows[0] = '{fa_pkg::index_t'(`FA_DEF_P0_START), fa_pkg::index_t'(`FA_DEF_P0_STOP)};
        windows[1] = '{fa_pkg::index_t'(`FA_DEF_P1_START), fa_pkg::index_t'(`FA_DEF_P1_STOP)};
        windows[2] = '{fa_pkg::index_t'(`FA_DEF_P2_START), fa_pkg::index_t'(`FA_DEF_P2_STOP)};
        clear_model();

        repeat (2) @(posedge pixel_clock);
        rst_n <= 1'b1;

        // reset defaults
        @(negedge pixel_clock);
        check_value("done", fa_pkg::result_t'(done), '0);
        check_results();
        read_result(fa_pkg::result_addr_e'(4'd9), value);
        check_value("read_data unmapped", value, '0);

        // default windows, blinking at 4, 8 and 6 lines
        set_pattern(0, 4, `FA_DEF_P0_START + 4, `FA_DEF_P0_STOP - 4);
        set_pattern(1, 8, `FA_DEF_P1_START + 4, `FA_DEF_P1_STOP - 4);
        set_pattern(2, 6, `FA_DEF_P2_START + 4, `FA_DEF_P2_STOP - 4);
        run_lines(24);
        check_results();

        // move point 0 and raise the threshold, old window stays dark
        write_cfg(fa_pkg::P0_START, 100);
        write_cfg(fa_pkg::P0_STOP, 140);
        write_cfg(fa_pkg::THRESHOLD, 150);
        windows[0] = '{fa_pkg::index_t'(100), fa_pkg::index_t'(140)};
        threshold_model = fa_pkg::pixel_t'(150);
        set_pattern(0, 5, 100, 140);
        // point 1 midpoint lands between the old and the new threshold
        set_pattern(1, 8, `FA_DEF_P1_START + 4, `FA_DEF_P1_STOP - 4);
        set_pattern(2, 0, 0, 0);
        run_lines(16);
        check_results();

        // done holds after stop, clear empties the totals
        check_value("done", fa_pkg::result_t'(done), 32'd1);
        @(posedge pixel_clock);
        clear <= 1'b1;
        @(posedge pixel_clock);
        clear <= 1'b0;
        clear_model();
        check_results();

        $display("** PASS **");
        $finish;
    end

endmodule

// File: fa_assert.sv
`timescale 1ns/10ps
`include "fa_cfg.svh"

module fa_assert (
    input  logic                 pixel_clock,
    input  logic                 rst_n,
    input  fa_pkg::index_t       index,
    input  logic                 line_end,
    input  logic                 active,
    input  logic                 done,
    input  fa_pkg::result_addr_e read_addr,
    input  fa_pkg::result_t      read_data
);

    localparam int LAST_INDEX   = `FA_DARK_PIXELS + `FA_COLOR_PIXELS;
    localparam int RESULT_COUNT = 3 * `FA_POINTS;

    index_range: assert property (@(posedge pixel_clock) disable iff (!rst_n)
        int'(index) <= LAST_INDEX)
        else $error("pixel index %0d is past the end of the line", index);

    line_end_place: assert property (@(posedge pixel_clock) disable iff (!rst_n)
        line_end |-> int'(index) == LAST_INDEX)
        else $error("line end strobe at index %0d", index);

    run_state: assert property (@(posedge pixel_clock) disable iff (!rst_n)
        !(active && done))
        else $error("active and done are high together");

    // addresses past the nine results read zero
    unmapped_read: assert property (@(posedge pixel_clock) disable iff (!rst_n)
        int'(read_addr) >= RESULT_COUNT |=> read_data == '0)
        else $error("unmapped read address returned 0x%h", read_data);

endmodule

bind freq_analyzer_top fa_assert i_assert (
    .pixel_clock (pixel_clock),
    .rst_n       (rst_n),
    .index       (line_bus.index),
    .line_end    (line_bus.line_end),
    .active      (line_bus.active),
    .done        (done),
    .read_addr   (read_addr),
    .read_data   (read_data)
);

// File: freq_analyzer_top.sv
`timescale 1ns/10ps
`include "fa_cfg.svh"

module freq_analyzer_top (
    input  logic                 pixel_clock,
    input  logic                 rst_n,
    input  logic                 start,
    input  logic                 stop,
    input  logic                 clear,
    input  fa_pkg::pixel_t       data,
    input  logic                 cfg_write,
    input  fa_pkg::cfg_addr_e    cfg_addr,
    input  fa_pkg::index_t       cfg_data,
    input  fa_pkg::result_addr_e read_addr,
    output fa_pkg::result_t      read_data,
    output logic                 done
);

    fa_pkg::pixel_t          threshold;
    fa_pkg::window_t         window [`FA_POINTS];
    logic [`FA_POINTS-1:0]   light;
    fa_pkg::result_t         f0_time [`FA_POINTS];
    fa_pkg::result_t         f1_time [`FA_POINTS];
    fa_pkg::result_t         unknown_time [`FA_POINTS];

    line_if line_bus ();

    scan_timing u_scan (
        .pixel_clock (pixel_clock),
        .rst_n       (rst_n),
        .start       (start),
        .stop        (stop),
        .data        (data),
        .bus         (line_bus),
        .done        (done)
    );

    config_regs u_regs (
        .pixel_clock (pixel_clock),
        .rst_n       (rst_n),
        .cfg_write   (cfg_write),
        .cfg_addr    (cfg_addr),
        .cfg_data    (cfg_data),
        .read_addr   (read_addr),
        .p0_f0       (f0_time[0]),
        .p0_f1       (f1_time[0]),
        .p0_unknown  (unknown_time[0]),
        .p1_f0       (f0_time[1]),
        .p1_f1       (f1_time[1]),
        .p1_unknown  (unknown_time[1]),
        .p2_f0       (f0_time[2]),
        .p2_f1       (f1_time[2]),
        .p2_unknown  (unknown_time[2]),
        .threshold   (threshold),
        .window0     (window[0]),
        .window1     (window[1]),
        .window2     (window[2]),
        .read_data   (read_data)
    );

    // one window and one classifier per light point
    for (genvar i = 0; i < `FA_POINTS; i++)
    begin : g_point
        point_window u_window (
            .pixel_clock (pixel_clock),
            .rst_n       (rst_n),
            .bus         (line_bus),
            .window      (window[i]),
            .threshold   (threshold),
            .light       (light[i])
        );

        blink_classifier u_blink (
            .pixel_clock  (pixel_clock),
            .rst_n        (rst_n),
            .bus          (line_bus),
            .clear        (clear),
            .light        (light[i]),
            .f0_time      (f0_time[i]),
            .f1_time      (f1_time[i]),
            .unknown_time (unknown_time[i])
        );
    end

endmodule

// File: config_regs.sv
`timescale 1ns/10ps
`include "fa_cfg.svh"

module config_regs (
    input  logic                 pixel_clock,
    input  logic                 rst_n,
    input  logic                 cfg_write,
    input  fa_pkg::cfg_addr_e    cfg_addr,
    input  fa_pkg::index_t       cfg_data,
    input  fa_pkg::result_addr_e read_addr,
    input  fa_pkg::result_t      p0_f0,
    input  fa_pkg::result_t      p0_f1,
    input  fa_pkg::result_t      p0_unknown,
    input  fa_pkg::result_t      p1_f0,
    input  fa_pkg::result_t      p1_f1,
    input  fa_pkg::result_t      p1_unknown,
    input  fa_pkg::result_t      p2_f0,
    input  fa_pkg::result_t      p2_f1,
    input  fa_pkg::result_t      p2_unknown,
    output fa_pkg::pixel_t       threshold,
    output fa_pkg::window_t      window0,
    output fa_pkg::window_t      window1,
    output fa_pkg::window_t      window2,
    output fa_pkg::result_t      read_data
);

    ////////////////////////////////////////////////////////////////////////////
    // writable registers
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge pixel_clock)
    begin
        if (!rst_n)
        begin
            threshold     <= fa_pkg::pixel_t'(`FA_DEF_THRESHOLD);
            window0.start <= fa_pkg::index_t'(`FA_DEF_P0_START);
            window0.stop  <= fa_pkg::index_t'(`FA_DEF_P0_STOP);
            window1.start <= fa_pkg::index_t'(`FA_DEF_P1_START);
            window1.stop  <= fa_pkg::index_t'(`FA_DEF_P1_STOP);
            window2.start <= fa_pkg::index_t'(`FA_DEF_P2_START);
            window2.stop  <= fa_pkg::index_t'(`FA_DEF_P2_STOP);
        end
        else if (cfg_write)
        begin
            case (cfg_addr)
                // threshold takes the low byte only
                fa_pkg::THRESHOLD: threshold     <= cfg_data[`FA_DATA_W-1:0];
                fa_pkg::P0_START:  window0.start <= cfg_data;
                fa_pkg::P0_STOP:   window0.stop  <= cfg_data;
                fa_pkg::P1_START:  window1.start <= cfg_data;
                fa_pkg::P1_STOP:   window1.stop  <= cfg_data;
                fa_pkg::P2_START:  window2.start <= cfg_data;
                fa_pkg::P2_STOP:   window2.stop  <= cfg_data;
                default:
                begin
                end
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // result readback
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge pixel_clock)
    begin
        if (!rst_n)
            read_data <= '0;
        else
        begin
            case (read_addr)
                fa_pkg::P0_F0:      read_data <= p0_f0;
                fa_pkg::P0_F1:      read_data <= p0_f1;
                fa_pkg::P1_F0:      read_data <= p1_f0;
                fa_pkg::P1_F1:      read_data <= p1_f1;
                fa_pkg::P2_F0:      read_data <= p2_f0;
                fa_pkg::P2_F1:      read_data <= p2_f1;
                fa_pkg::P0_UNKNOWN: read_data <= p0_unknown;
                fa_pkg::P1_UNKNOWN: read_data <= p1_unknown;
                fa_pkg::P2_UNKNOWN: read_data <= p2_unknown;
                default:            read_data <= '0;
            endcase
        end
    end

endmodule

// File: blink_classifier.sv
`timescale 1ns/10ps
`include "fa_cfg.svh"

module blink_classifier (
    input  logic             pixel_clock,
    input  logic             rst_n,
    line_if.point            bus,
    input  logic             clear,
    input  logic             light,
    output fa_pkg::result_t  f0_time,
    output fa_pkg::result_t  f1_time,
    output fa_pkg::result_t  unknown_time
);

    typedef logic [`FA_PERIOD_W-1:0] period_t;

    localparam period_t F0_LO = period_t'(`FA_F0_PERIOD - `FA_DEVIATION);
    localparam period_t F0_HI = period_t'(`FA_F0_PERIOD + `FA_DEVIATION);
    localparam period_t F1_LO = period_t'(`FA_F1_PERIOD - `FA_DEVIATION);
    localparam period_t F1_HI = period_t'(`FA_F1_PERIOD + `FA_DEVIATION);

    logic    light_q;
    logic    rise;
    logic    armed;
    period_t period;
    logic    in_f0;
    logic    in_f1;

    assign rise  = light && !light_q;
    assign in_f0 = (period >= F0_LO) && (period <= F0_HI);
    assign in_f1 = (period >= F1_LO) && (period <= F1_HI);

    always_ff @(posedge pixel_clock)
    begin
        if (!rst_n)
            light_q <= 1'b0;
        else
            light_q <= light;
    end

    ////////////////////////////////////////////////////////////////////////////
    // period counter and accumulators
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge pixel_clock)
    begin
        if (!rst_n || clear)
        begin
            armed        <= 1'b0;
            period       <= '0;
            f0_time      <= '0;
            f1_time      <= '0;
            unknown_time <= '0;
        end
        else if (!bus.active)
        begin
            // totals stay readable after stop
            armed  <= 1'b0;
            period <= '0;
        end
        else if (rise)
        begin
            armed  <= 1'b1;
            period <= period_t'(bus.line_end);
            // first edge of a run only arms
            if (armed)
            begin
                if (in_f0)
                    f0_time <= f0_time + fa_pkg::result_t'(period);
                else if (in_f1)
                    f1_time <= f1_time + fa_pkg::result_t'(period);
                else
                    unknown_time <= unknown_time + fa_pkg::result_t'(period);
            end
        end
        else if (bus.line_end && period != '1)
        begin
            period <= period + 1'b1;
        end
    end

endmodule

// File: point_window.sv
`timescale 1ns/10ps
`include "fa_cfg.svh"

module point_window (
    input  logic             pixel_clock,
    input  logic             rst_n,
    line_if.point            bus,
    input  fa_pkg::window_t  window,
    input  fa_pkg::pixel_t   threshold,
    output logic             light
);

    fa_pkg::pixel_t max_value;
    fa_pkg::pixel_t min_value;
    fa_pkg::pixel_t spread;
    fa_pkg::pixel_t midpoint;
    logic           in_window;
    logic           at_stop;

    assign in_window = (bus.index >= window.start) && (bus.index < window.stop);
    assign at_stop   = (bus.index == window.stop);

    // half the spread, truncated, never overflows past max
    assign spread   = max_value - min_value;
    assign midpoint = min_value + (spread >> 1);

    ////////////////////////////////////////////////////////////////////////////
    // extremes and decision
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge pixel_clock)
    begin
        if (!rst_n || !bus.active)
        begin
            max_value <= '0;
            min_value <= '1;
            light     <= 1'b0;
        end
        else if (at_stop)
        begin
            light     <= (midpoint > threshold);
            // re-arm for the next line
            max_value <= '0;
            min_value <= '1;
        end
        else if (in_window)
        begin
            if (bus.pixel > max_value)
                max_value <= bus.pixel;
            if (bus.pixel < min_value)
                min_value <= bus.pixel;
        end
    end

endmodule

// File: scan_timing.sv
`timescale 1ns/10ps
`include "fa_cfg.svh"

module scan_timing (
    input  logic            pixel_clock,
    input  logic            rst_n,
    input  logic            start,
    input  logic            stop,
    input  fa_pkg::pixel_t  data,
    line_if.scanner         bus,
    output logic            done
);

    localparam fa_pkg::index_t LAST_INDEX =
        fa_pkg::index_t'(`FA_DARK_PIXELS + `FA_COLOR_PIXELS);

    logic enable;

    ////////////////////////////////////////////////////////////////////////////
    // run control
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge pixel_clock)
    begin
        if (!rst_n)
        begin
            enable <= 1'b0;
            done   <= 1'b0;
        end
        else if (start)
        begin
            enable <= 1'b1;
            done   <= 1'b0;
        end
        else if (stop)
        begin
            enable <= 1'b0;
            done   <= 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // pixel index and data
    ////////////////////////////////////////////////////////////////////////////

    // index parks at 0 while idle and on the stop edge
    always_ff @(posedge pixel_clock)
    begin
        if (!rst_n)
            bus.index <= '0;
        else if (!enable || stop || bus.index == LAST_INDEX)
            bus.index <= '0;
        else
            bus.index <= bus.index + 1'b1;
    end

    always_ff @(posedge pixel_clock)
    begin
        bus.pixel <= data;
    end

    assign bus.active   = enable;
    assign bus.line_end = enable && (bus.index == LAST_INDEX);

endmodule

// File: line_if.sv
`timescale 1ns/10ps
`include "fa_cfg.svh"

interface line_if;

    logic [`FA_DATA_W-1:0] pixel;
    logic [`FA_INDEX_W-1:0] index;
    logic line_end;
    logic active;

    modport scanner (
        output pixel,
        output index,
        output line_end,
        output active
    );

    modport point (
        input pixel,
        input index,
        input line_end,
        input active
    );

endinterface

// File: fa_pkg.sv
`include "fa_cfg.svh"

package fa_pkg;

    typedef logic [`FA_DATA_W-1:0] pixel_t;
    typedef logic [`FA_INDEX_W-1:0] index_t;
    typedef logic [`FA_RESULT_W-1:0] result_t;

    // window covers start .. stop-1, decision at stop
    typedef struct packed {
        index_t start;
        index_t stop;
    } window_t;

    typedef enum logic [2:0] {
        THRESHOLD = 3'd0,
        P0_START  = 3'd1,
        P0_STOP   = 3'd2,
        P1_START  = 3'd3,
        P1_STOP   = 3'd4,
        P2_START  = 3'd5,
        P2_STOP   = 3'd6
    } cfg_addr_e;

    // unknown counters sit after the six band counters
    typedef enum logic [3:0] {
        P0_F0      = 4'd0,
        P0_F1      = 4'd1,
        P1_F0      = 4'd2,
        P1_F1      = 4'd3,
        P2_F0      = 4'd4,
        P2_F1      = 4'd5,
        P0_UNKNOWN = 4'd6,
        P1_UNKNOWN = 4'd7,
        P2_UNKNOWN = 4'd8
    } result_addr_e;

endpackage

// File: fa_cfg.svh
`ifndef FA_CFG_SVH
`define FA_CFG_SVH

// pixel and index widths
`define FA_DATA_W 8
`define FA_INDEX_W 11

// line geometry, indices 0 .. dark + color
`define FA_DARK_PIXELS 16
`define FA_COLOR_PIXELS 1024

// reset defaults of the config registers
`define FA_DEF_THRESHOLD 96
`define FA_DEF_P0_START 18
`define FA_DEF_P0_STOP 50
`define FA_DEF_P1_START 272
`define FA_DEF_P1_STOP 304
`define FA_DEF_P2_START 784
`define FA_DEF_P2_STOP 816

// blink periods in lines
`define FA_F0_PERIOD 4
`define FA_F1_PERIOD 8
`define FA_DEVIATION 1

`define FA_PERIOD_W 12
`define FA_RESULT_W 32
`define FA_POINTS 3

`endif
